/* hw/axis_conv_defs.svh */
// Stream width converter defines
// Beat widths, buffer depths and metadata field sizes

`ifndef AXIS_CONV_DEFS_SVH
`define AXIS_CONV_DEFS_SVH

//////////////////////////////
// Beat widths in bytes
//////////////////////////////
`define AXIS_IN_BYTES    8
`define AXIS_OUT_BYTES   4

// Buffer depths
`define BEAT_FIFO_DEPTH  32   // Wide beats, bounds max packet size
`define META_FIFO_DEPTH  8    // Packets queued

// Metadata fields
`define LEN_WIDTH        16
`define PORT_WIDTH       8

`endif

/* hw/axis_conv_pkg.sv */
// Stream width converter types
// Wide and narrow beat structs plus the per-packet metadata word

`include "axis_conv_defs.svh"

package axis_conv_pkg;

   //////////////////////////////
   // Stream beats
   //////////////////////////////

   // Input side beat, also the beat buffer entry
   typedef struct packed {
      logic [`AXIS_IN_BYTES*8-1:0] data;
      logic [`AXIS_IN_BYTES-1:0]   strb;
      logic                        last;
   } wide_beat_t;

   // Output side beat
   typedef struct packed {
      logic [`AXIS_OUT_BYTES*8-1:0] data;
      logic [`AXIS_OUT_BYTES-1:0]   strb;
      logic                         last;
   } narrow_beat_t;

   //////////////////////////////
   // Packet metadata
   //////////////////////////////

   // Held on the output sideband for a whole packet
   typedef struct packed {
      logic [`LEN_WIDTH-1:0]  len;       // Bytes in packet
      logic [`PORT_WIDTH-1:0] src_port;  // Port tag of first beat
   } pkt_meta_t;

endpackage

/* hw/fallthrough_fifo.sv */
// First-word-fall-through FIFO
// Circular buffer whose head entry shows on dout while empty is low.
// Payload type is a parameter so one block buffers beats or metadata.
// nearly_full rises when one free slot or less remains.

`timescale 1ns/1ns

module fallthrough_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  DEPTH     = 16
) (
   input  logic     axi_aclk,
   input  logic     axi_resetn,
   input  logic     wr_en,
   input  payload_t din,
   input  logic     rd_en,
   output payload_t dout,
   output logic     empty,
   output logic     nearly_full
);

   localparam int PTR_W = $clog2(DEPTH);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;     // Occupancy
   logic             do_wr;
   logic             do_rd;

   assign do_rd = rd_en & ~empty;
   assign do_wr = wr_en & (count != (PTR_W+1)'(DEPTH));   // Drop on overflow

   assign empty       = (count == '0);
   assign nearly_full = (count >= (PTR_W+1)'(DEPTH - 1));
   assign dout        = mem[rd_ptr];     // Head falls through

   // Storage
   always_ff @(posedge axi_aclk) begin
      if (do_wr) mem[wr_ptr] <= din;
   end

   // Pointers and count
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_wr && !do_rd) count <= count + 1'b1;
         else if (do_rd && !do_wr) count <= count - 1'b1;
      end
   end

endmodule

/* hw/axis_len_counter.sv */
// Packet length counter
// Accepts wide input beats and passes every one into the beat buffer.
// Sums packet bytes from the strobes and latches the source port, then
// writes one metadata entry on the last beat of each packet.

`timescale 1ns/1ns
`include "axis_conv_defs.svh"

module axis_len_counter (
   input  logic                      axi_aclk,
   input  logic                      axi_resetn,
   input  logic                      s_valid,
   output logic                      s_ready,
   input  axis_conv_pkg::wide_beat_t s_beat,
   input  logic [`PORT_WIDTH-1:0]    s_src_port,
   output logic                      beat_wr_en,
   output axis_conv_pkg::wide_beat_t beat_din,
   input  logic                      beat_nearly_full,
   output logic                      meta_wr_en,
   output axis_conv_pkg::pkt_meta_t  meta_din,
   input  logic                      meta_nearly_full
);
   import axis_conv_pkg::*;

   localparam int CNT_W = $clog2(`AXIS_IN_BYTES) + 1;
   localparam int LEN_W = `LEN_WIDTH;

   logic                   accept;
   logic                   first_beat;   // Next beat opens a packet
   logic [CNT_W-1:0]       beat_bytes;
   logic [LEN_W-1:0]       len_q;
   logic [LEN_W-1:0]       len_sum;
   logic [`PORT_WIDTH-1:0] port_q;
   logic [`PORT_WIDTH-1:0] port_cur;

   assign s_ready = ~beat_nearly_full & ~meta_nearly_full;
   assign accept  = s_valid & s_ready;

   // Bytes in beat = highest set strobe lane + 1
   always_comb begin
      beat_bytes = '0;
      for (int i = 0; i < `AXIS_IN_BYTES; i++) begin
         if (s_beat.strb[i]) beat_bytes = CNT_W'(i + 1);
      end
   end

   assign len_sum  = len_q + LEN_W'(beat_bytes);
   assign port_cur = first_beat ? s_src_port : port_q;   // One-beat packets

   assign beat_wr_en = accept;
   assign beat_din   = s_beat;
   assign meta_wr_en = accept & s_beat.last;
   assign meta_din   = pkt_meta_t'{len: len_sum, src_port: port_cur};

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         len_q      <= '0;
         first_beat <= 1'b1;
      end else if (accept) begin
         len_q      <= s_beat.last ? '0 : len_sum;
         first_beat <= s_beat.last;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (accept && first_beat) port_q <= s_src_port;
   end

endmodule

/* hw/axis_downsizer.sv */
// Stream downsizer
// Splits each buffered wide beat into narrow beats, low half first.
// The last narrow word is found from the strobes of the next slice.
// Packet metadata is shown from the metadata buffer head for the whole
// packet and popped with the last narrow word.

`timescale 1ns/1ns
`include "axis_conv_defs.svh"

module axis_downsizer (
   input  logic                        axi_aclk,
   input  logic                        axi_resetn,
   input  axis_conv_pkg::wide_beat_t   beat_dout,
   input  logic                        beat_empty,
   output logic                        beat_rd_en,
   input  axis_conv_pkg::pkt_meta_t    meta_dout,
   input  logic                        meta_empty,
   output logic                        meta_rd_en,
   output logic                        m_valid,
   input  logic                        m_ready,
   output axis_conv_pkg::narrow_beat_t m_beat,
   output axis_conv_pkg::pkt_meta_t    m_meta
);
   import axis_conv_pkg::*;

   localparam int OUT_BYTES = `AXIS_OUT_BYTES;
   localparam int OUT_W     = OUT_BYTES * 8;
   localparam int SLICES    = `AXIS_IN_BYTES / `AXIS_OUT_BYTES;
   localparam int SL_W      = $clog2(SLICES);

   logic [SL_W-1:0]      slice;       // Which narrow part of the head beat
   logic                 top_slice;
   logic [OUT_BYTES-1:0] next_strb;
   logic                 word_last;
   logic                 xfer;

   //////////////////////////////
   // Slice selection
   //////////////////////////////

   assign top_slice = (slice == SL_W'(SLICES - 1));

   // Strobes of the slice after this one, zero past the top
   always_comb begin
      next_strb = '0;
      for (int i = 1; i < SLICES; i++) begin
         if (slice == SL_W'(i - 1)) next_strb = beat_dout.strb[i*OUT_BYTES +: OUT_BYTES];
      end
   end

   assign word_last = beat_dout.last & (top_slice | ~|next_strb);

   //////////////////////////////
   // Output and pops
   //////////////////////////////

   // Metadata must be present too, so a packet starts only once complete
   assign m_valid = ~beat_empty & ~meta_empty;
   assign xfer    = m_valid & m_ready;

   assign m_beat = narrow_beat_t'{
      data: beat_dout.data[slice*OUT_W +: OUT_W],
      strb: beat_dout.strb[slice*OUT_BYTES +: OUT_BYTES],
      last: word_last
   };
   assign m_meta = meta_dout;

   assign beat_rd_en = xfer & (top_slice | word_last);
   assign meta_rd_en = xfer & word_last;          // End of packet

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         slice <= '0;
      end else if (xfer) begin
         if (beat_rd_en) slice <= '0;    // Next wide beat starts low
         else slice <= slice + 1'b1;
      end
   end

endmodule

/* hw/axis_converter_top.sv */
// Stream width converter top
// 64-bit packet stream in, 32-bit stream out with a length and source
// port metadata word held on the output sideband for each packet.
// Producer, beat and metadata buffers, consumer.

`timescale 1ns/1ns
`include "axis_conv_defs.svh"

module axis_converter_top (
   input  logic                        axi_aclk,
   input  logic                        axi_resetn,
   input  logic                        s_valid,
   output logic                        s_ready,
   input  axis_conv_pkg::wide_beat_t   s_beat,
   input  logic [`PORT_WIDTH-1:0]      s_src_port,
   output logic                        m_valid,
   input  logic                        m_ready,
   output axis_conv_pkg::narrow_beat_t m_beat,
   output axis_conv_pkg::pkt_meta_t    m_meta
);
   import axis_conv_pkg::*;

   wide_beat_t beat_din, beat_dout;
   pkt_meta_t  meta_din, meta_dout;
   logic       beat_wr_en, beat_rd_en, beat_empty, beat_nearly_full;
   logic       meta_wr_en, meta_rd_en, meta_empty, meta_nearly_full;

   //////////////////////////////
   // Producer
   //////////////////////////////
   axis_len_counter u_len_counter (
      .axi_aclk         (axi_aclk),
      .axi_resetn       (axi_resetn),
      .s_valid          (s_valid),
      .s_ready          (s_ready),
      .s_beat           (s_beat),
      .s_src_port       (s_src_port),
      .beat_wr_en       (beat_wr_en),
      .beat_din         (beat_din),
      .beat_nearly_full (beat_nearly_full),
      .meta_wr_en       (meta_wr_en),
      .meta_din         (meta_din),
      .meta_nearly_full (meta_nearly_full)
   );

   //////////////////////////////
   // Buffers
   //////////////////////////////
   fallthrough_fifo #(
      .payload_t (wide_beat_t),
      .DEPTH     (`BEAT_FIFO_DEPTH)
   ) u_beat_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .wr_en       (beat_wr_en),
      .din         (beat_din),
      .rd_en       (beat_rd_en),
      .dout        (beat_dout),
      .empty       (beat_empty),
      .nearly_full (beat_nearly_full)
   );

   fallthrough_fifo #(
      .payload_t (pkt_meta_t),
      .DEPTH     (`META_FIFO_DEPTH)
   ) u_meta_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .wr_en       (meta_wr_en),
      .din         (meta_din),
      .rd_en       (meta_rd_en),
      .dout        (meta_dout),
      .empty       (meta_empty),
      .nearly_full (meta_nearly_full)
   );

   //////////////////////////////
   // Consumer
   //////////////////////////////
   axis_downsizer u_downsizer (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .beat_dout  (beat_dout),
      .beat_empty (beat_empty),
      .beat_rd_en (beat_rd_en),
      .meta_dout  (meta_dout),
      .meta_empty (meta_empty),
      .meta_rd_en (meta_rd_en),
      .m_valid    (m_valid),
      .m_ready    (m_ready),
      .m_beat     (m_beat),
      .m_meta     (m_meta)
   );

endmodule

/* dv/axis_conv_checker.sv */
// Output checker for the stream width converter
// Models the narrow beats and metadata expected from each accepted input
// beat and compares them with every output transfer, including hold
// stability while the output is stalled

`timescale 1ns/1ns
`include "axis_conv_defs.svh"

module axis_conv_checker (
   input  logic                        axi_aclk,
   input  logic                        axi_resetn,
   input  logic                        s_valid,
   input  logic                        s_ready,
   input  axis_conv_pkg::wide_beat_t   s_beat,
   input  logic [`PORT_WIDTH-1:0]      s_src_port,
   input  logic                        m_valid,
   input  logic                        m_ready,
   input  axis_conv_pkg::narrow_beat_t m_beat,
   input  axis_conv_pkg::pkt_meta_t    m_meta,
   output int                          error_count,
   output int                          pkts_in,
   output int                          pkts_out,
   output int                          beats_left,
   output int                          meta_left
);
   import axis_conv_pkg::*;

   localparam int OUT_B  = `AXIS_OUT_BYTES;
   localparam int OUT_W  = OUT_B * 8;
   localparam int SLICES = `AXIS_IN_BYTES / `AXIS_OUT_BYTES;

   narrow_beat_t           exp_beats [$];
   pkt_meta_t              exp_meta [$];     // Head is the packet on the output
   logic [`LEN_WIDTH-1:0]  len_acc;
   logic [`PORT_WIDTH-1:0] port_acc;
   logic                   in_pkt;
   logic                   held;             // Output stalled at the last edge
   narrow_beat_t           held_beat;
   pkt_meta_t              held_meta;

   task automatic report_diff(input string name, input logic [63:0] expv,
                              input logic [63:0] actv);
      $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, expv, actv);
      error_count++;
   endtask

   // Split one accepted wide beat into its expected narrow beats
   task automatic push_input(input wide_beat_t b, input logic [`PORT_WIDTH-1:0] port);
      narrow_beat_t         nb;
      pkt_meta_t            pm;
      if (!in_pkt) begin
         port_acc = port;    // Port counts on the first beat only
         len_acc  = '0;
      end
      len_acc = len_acc + `LEN_WIDTH'($countones(b.strb));
      in_pkt  = !b.last;
      for (int k = 0; k < SLICES; k++) begin
         nb.data = OUT_W'(b.data >> (k * OUT_W));
         nb.strb = OUT_B'(b.strb >> (k * OUT_B));
         nb.last = 1'b0;
         if (k > 0 && nb.strb == '0) break;   // Empty upper slice never goes out
         exp_beats.push_back(nb);
      end
      if (b.last) begin
         nb      = exp_beats.pop_back();   // Final narrow word of the packet
         nb.last = 1'b1;
         exp_beats.push_back(nb);
         pm.len      = len_acc;
         pm.src_port = port_acc;
         exp_meta.push_back(pm);
         pkts_in++;
      end
   endtask

   task automatic check_output();
      narrow_beat_t e;
      if (exp_beats.size() == 0) begin
         $display("Error at %0t: output beat with no input data left to match", $time);
         error_count++;
      end else begin
         e = exp_beats.pop_front();
         if (m_beat.data !== e.data) report_diff("m_beat.data", 64'(e.data), 64'(m_beat.data));
         if (m_beat.strb !== e.strb) report_diff("m_beat.strb", 64'(e.strb), 64'(m_beat.strb));
         if (m_beat.last !== e.last) report_diff("m_beat.last", 64'(e.last), 64'(m_beat.last));
      end
      if (exp_meta.size() == 0) begin
         $display("Error at %0t: output beat sent before its packet was complete", $time);
         error_count++;
      end else begin
         if (m_meta.len !== exp_meta[0].len)
            report_diff("m_meta.len", 64'(exp_meta[0].len), 64'(m_meta.len));
         if (m_meta.src_port !== exp_meta[0].src_port)
            report_diff("m_meta.src_port", 64'(exp_meta[0].src_port), 64'(m_meta.src_port));
         if (m_beat.last) begin
            exp_meta.delete(0);
            pkts_out++;
         end
      end
   endtask

   //////////////////////////////
   // Sampling at the rising edge
   //////////////////////////////
   always @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         in_pkt = 1'b0;
         held   = 1'b0;
      end else begin
         if (held) begin
            if (m_valid !== 1'b1) begin
               $display("Error at %0t: m_valid dropped before its beat was taken", $time);
               error_count++;
            end else begin
               if (m_beat !== held_beat)
                  report_diff("m_beat (stalled)", 64'(held_beat), 64'(m_beat));
               if (m_meta !== held_meta)
                  report_diff("m_meta (stalled)", 64'(held_meta), 64'(m_meta));
            end
         end
         if (m_valid && m_ready) check_output();
         if (s_valid && s_ready) push_input(s_beat, s_src_port);
         held      = m_valid && !m_ready;
         held_beat = m_beat;
         held_meta = m_meta;
      end
      beats_left = exp_beats.size();
      meta_left  = exp_meta.size();
   end

endmodule

/* dv/tb_axis_converter.sv */
// Testbench for the stream width converter
// Random packets from a seeded LCG with input gaps, random output
// back-pressure, a checker module and a cycle timeout

`timescale 1ns/1ns
`include "axis_conv_defs.svh"

module tb_axis_converter;
   import axis_conv_pkg::*;

   localparam int          NUM_PKTS       = 200;
   localparam int          MAX_BEATS      = 24;
   localparam int          TIMEOUT_CYCLES = NUM_PKTS * 48 * 4 + 1000;
   localparam logic [31:0] SEED           = 32'h334a_5578;

   logic                   axi_aclk;
   logic                   axi_resetn;
   logic                   s_valid;
   logic                   s_ready;
   wide_beat_t             s_beat;
   logic [`PORT_WIDTH-1:0] s_src_port;
   logic                   m_valid;
   logic                   m_ready;
   narrow_beat_t           m_beat;
   pkt_meta_t              m_meta;

   logic [31:0] rng_state = SEED;
   int          tb_errors = 0;
   int          timeout_errors = 0;
   int          cycles = 0;
   int          chk_errors, pkts_in, pkts_out, beats_left, meta_left;

   axis_converter_top i_dut (.*);

   axis_conv_checker u_checker (
      .error_count (chk_errors),
      .pkts_in     (pkts_in),
      .pkts_out    (pkts_out),
      .beats_left  (beats_left),
      .meta_left   (meta_left),
      .*
   );

   initial begin
      axi_aclk = 1'b0;
      forever #2 axi_aclk = ~axi_aclk;
   end

   function automatic logic [31:0] lcg_next();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic int rand_range(input int n);
      return int'((lcg_next() >> 8) % 32'(n));   // Upper bits, low ones are weak
   endfunction

   // Falling edge, then fresh back-pressure for the coming cycle
   task automatic next_cycle();
      @(negedge axi_aclk);
      m_ready = (rand_range(3) != 0);
   endtask

   task automatic send_beat(input wide_beat_t b, input logic [`PORT_WIDTH-1:0] port);
      logic taken;
      while (rand_range(4) == 0) begin
         s_valid = 1'b0;
         next_cycle();
      end
      s_valid    = 1'b1;
      s_beat     = b;
      s_src_port = port;
      taken      = 1'b0;
      while (!taken) begin
         taken = s_ready;    // Holds until the next rising edge
         next_cycle();
      end
      s_valid = 1'b0;
   endtask

   task automatic send_packet();
      int                     nbeats;
      int                     nbytes;
      logic [`PORT_WIDTH-1:0] port;
      wide_beat_t             b;
      nbeats = 1 + rand_range(MAX_BEATS);
      nbytes = 1 + rand_range(`AXIS_IN_BYTES);
      port   = `PORT_WIDTH'(lcg_next() >> 24);
      for (int i = 0; i < nbeats; i++) begin
         b.data = {lcg_next(), lcg_next()};
         b.last = (i == nbeats - 1);
         b.strb = b.last ? 8'(8'hff >> (8 - nbytes)) : 8'hff;
         // Later beats carry a junk port, the DUT must ignore it
         send_beat(b, (i == 0) ? port : `PORT_WIDTH'(lcg_next() >> 24));
      end
   endtask

   task automatic finish_run();
      int total;
      total = chk_errors + tb_errors + timeout_errors;
      $display("Errors: %0d (checker %0d, testbench %0d, timeout %0d), packets in %0d, out %0d",
               total, chk_errors, tb_errors, timeout_errors, pkts_in, pkts_out);
      if (total == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial begin
      axi_resetn = 1'b0;
      s_valid    = 1'b0;
      s_beat     = '0;
      s_src_port = '0;
      m_ready    = 1'b0;
      repeat (2) @(negedge axi_aclk);
      axi_resetn = 1'b1;
      if (m_valid !== 1'b0) begin
         $display("Mismatch at %0t: m_valid expected 0 got %b", $time, m_valid);
         tb_errors++;
      end
      if (s_ready !== 1'b1) begin
         $display("Mismatch at %0t: s_ready expected 1 got %b", $time, s_ready);
         tb_errors++;
      end
      for (int p = 0; p < NUM_PKTS; p++) send_packet();
      while (pkts_out < NUM_PKTS) next_cycle();
      repeat (4) next_cycle();
      if (beats_left != 0) begin
         $display("Error: %0d expected output beats were never sent", beats_left);
         tb_errors++;
      end
      if (meta_left != 0 || pkts_out != pkts_in) begin
         $display("Error: %0d packets went in but %0d came out", pkts_in, pkts_out);
         tb_errors++;
      end
      finish_run();
   end

   // Cycle limit
   always @(posedge axi_aclk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         timeout_errors++;
         finish_run();
      end
   end

endmodule

/* sim.f */
+incdir+hw
hw/axis_conv_pkg.sv
hw/fallthrough_fifo.sv
hw/axis_len_counter.sv
hw/axis_downsizer.sv
hw/axis_converter_top.sv
dv/axis_conv_checker.sv
dv/tb_axis_converter.sv

/* Makefile */
# Verilator flow for the stream width converter

VERILATOR ?= verilator
TOP       ?= tb_axis_converter
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^Everything OK$$" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
